// ==== source/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

  // Physical register tag, 64 tags
  parameter int TAG_W = 6;

  // Opaque reorder-buffer index carried with each micro-op
  parameter int PAYLOAD_W = 8;

  typedef logic [TAG_W-1:0]     tag_t;
  typedef logic [PAYLOAD_W-1:0] payload_t;

  // Wakeup slot lifecycle
  typedef enum logic [1:0] {
    SLOT_FREE  = 2'd0,
    SLOT_WAIT  = 2'd1,
    SLOT_READY = 2'd2
  } slot_state_t;

endpackage

`default_nettype wire

// ==== source/dispatch_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// One dispatched micro-op, loaded by the queue in the cycle it is valid
interface dispatch_if
  import issue_pkg::*;
();

  logic     valid;
  tag_t     dest;
  tag_t     src1;
  tag_t     src2;
  logic     src1_pending;
  logic     src2_pending;
  payload_t payload;

  modport source (
    output valid, dest, src1, src2, src1_pending, src2_pending, payload
  );

  modport sink (
    input valid, dest, src1, src2, src1_pending, src2_pending, payload
  );

endinterface

`default_nettype wire

// ==== source/issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// Selected micro-ops, one per execute lane
interface issue_if
  import issue_pkg::*;
#(
  parameter int ISSUE_WIDTH = 2
) ();

  logic     [ISSUE_WIDTH-1:0] valid;
  tag_t     [ISSUE_WIDTH-1:0] dest;
  payload_t [ISSUE_WIDTH-1:0] payload;

  modport source (
    output valid, dest, payload
  );

  modport sink (
    input valid, dest, payload
  );

endinterface

`default_nettype wire

// ==== source/dispatch_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module dispatch_stage
  import issue_pkg::*;
#(
  parameter int ISSUE_WIDTH = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   in_valid,
  input  tag_t                   in_dest,
  input  tag_t                   in_src1,
  input  tag_t                   in_src2,
  input  logic                   in_src1_used,
  input  logic                   in_src2_used,
  input  payload_t               in_payload,
  output logic                   in_ready,
  input  logic                   almost_full,
  input  logic [ISSUE_WIDTH-1:0] ctb_valid,
  input  tag_t [ISSUE_WIDTH-1:0] ctb_tag,
  dispatch_if.source             disp
);

  // One pending bit per physical register
  logic [2**TAG_W-1:0] busy;

  logic     accept;
  logic     src1_pending;
  logic     src2_pending;
  logic     valid_q;
  tag_t     dest_q;
  tag_t     src1_q;
  tag_t     src2_q;
  logic     pend1_q;
  logic     pend2_q;
  payload_t payload_q;

  function automatic logic on_bus(input tag_t tag);
    logic hit;
    hit = 1'b0;
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      hit = hit | (ctb_valid[l] && (ctb_tag[l] == tag));
    end
    return hit;
  endfunction

  assign in_ready = ~almost_full;
  assign accept   = in_valid & in_ready;

  // A tag produced this cycle is no longer pending
  always_comb begin
    src1_pending = in_src1_used && busy[in_src1] && !on_bus(in_src1);
    src2_pending = in_src2_used && busy[in_src2] && !on_bus(in_src2);
  end

  // Clears first, so a reused destination stays marked
  always_ff @(posedge clock) begin
    if (reset) begin
      busy <= '0;
    end else begin
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (ctb_valid[l]) begin
          busy[ctb_tag[l]] <= 1'b0;
        end
      end
      if (accept) begin
        busy[in_dest] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= accept;
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      dest_q    <= in_dest;
      src1_q    <= in_src1;
      src2_q    <= in_src2;
      pend1_q   <= src1_pending;
      pend2_q   <= src2_pending;
      payload_q <= in_payload;
    end
  end

  // Broadcasts during the register cycle still wake the micro-op
  always_comb begin
    disp.valid        = valid_q;
    disp.dest         = dest_q;
    disp.src1         = src1_q;
    disp.src2         = src2_q;
    disp.src1_pending = pend1_q && !on_bus(src1_q);
    disp.src2_pending = pend2_q && !on_bus(src2_q);
    disp.payload      = payload_q;
  end

  // A micro-op only enters the register when the queue had room
  assert property (@(posedge clock) disable iff (reset) disp.valid |-> !$past(almost_full))
    else $error("dispatch accepted while queue almost full");

endmodule

`default_nettype wire

// ==== source/issue_slot.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_slot
  import issue_pkg::*;
#(
  parameter int ISSUE_WIDTH = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   load,
  input  logic                   grant,
  input  logic [ISSUE_WIDTH-1:0] ctb_valid,
  input  tag_t [ISSUE_WIDTH-1:0] ctb_tag,
  input  tag_t                   dest_in,
  input  tag_t                   src1_in,
  input  tag_t                   src2_in,
  input  logic                   src1_pending_in,
  input  logic                   src2_pending_in,
  input  payload_t               payload_in,
  output slot_state_t            state,
  output tag_t                   dest,
  output payload_t               payload
);

  tag_t             src1;
  tag_t             src2;
  logic             src1_pending;
  logic             src2_pending;
  logic [ISSUE_WIDTH-1:0] src1_hit;
  logic [ISSUE_WIDTH-1:0] src2_hit;
  logic             src1_pending_next;
  logic             src2_pending_next;

  // On the load cycle the incoming tags are snooped
  always_comb begin
    for (int l = 0; l < ISSUE_WIDTH; l++) begin
      src1_hit[l] = ctb_valid[l] && (ctb_tag[l] == (load ? src1_in : src1));
      src2_hit[l] = ctb_valid[l] && (ctb_tag[l] == (load ? src2_in : src2));
    end
    src1_pending_next = (load ? src1_pending_in : src1_pending) && !(|src1_hit);
    src2_pending_next = (load ? src2_pending_in : src2_pending) && !(|src2_hit);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state        <= SLOT_FREE;
      src1_pending <= 1'b0;
      src2_pending <= 1'b0;
    end else begin
      src1_pending <= src1_pending_next;
      src2_pending <= src2_pending_next;
      if (grant) begin
        state <= SLOT_FREE;
      end else if (load || state == SLOT_WAIT) begin
        state <= (src1_pending_next || src2_pending_next) ? SLOT_WAIT : SLOT_READY;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (load) begin
      dest    <= dest_in;
      src1    <= src1_in;
      src2    <= src2_in;
      payload <= payload_in;
    end
  end

  // Allocation and selection in the queue must respect the slot state
  assert property (@(posedge clock) disable iff (reset) load |-> state == SLOT_FREE)
    else $error("slot loaded while occupied");

  assert property (@(posedge clock) disable iff (reset) grant |-> state == SLOT_READY)
    else $error("slot granted while not ready");

endmodule

`default_nettype wire

// ==== source/issue_queue.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_queue
  import issue_pkg::*;
#(
  parameter int IQ_SIZE     = 8,
  parameter int ISSUE_WIDTH = 2
) (
  input  logic                   clock,
  input  logic                   reset,
  dispatch_if.sink               disp,
  input  logic [ISSUE_WIDTH-1:0] ctb_valid,
  input  tag_t [ISSUE_WIDTH-1:0] ctb_tag,
  output logic                   almost_full,
  issue_if.source                iss
);

  slot_state_t slot_state   [IQ_SIZE];
  tag_t        slot_dest    [IQ_SIZE];
  payload_t    slot_payload [IQ_SIZE];

  logic [IQ_SIZE-1:0]           free;
  logic [IQ_SIZE-1:0]           ready;
  logic [IQ_SIZE-1:0]           load;
  logic [IQ_SIZE-1:0]           grant;
  logic [$clog2(IQ_SIZE+1)-1:0] free_count;

  for (genvar k = 0; k < IQ_SIZE; k++) begin : g_slot
    assign free[k]  = (slot_state[k] == SLOT_FREE);
    assign ready[k] = (slot_state[k] == SLOT_READY);

    issue_slot #(
      .ISSUE_WIDTH (ISSUE_WIDTH)
    ) u_slot (
      .clock           (clock),
      .reset           (reset),
      .load            (load[k]),
      .grant           (grant[k]),
      .ctb_valid       (ctb_valid),
      .ctb_tag         (ctb_tag),
      .dest_in         (disp.dest),
      .src1_in         (disp.src1),
      .src2_in         (disp.src2),
      .src1_pending_in (disp.src1_pending),
      .src2_pending_in (disp.src2_pending),
      .payload_in      (disp.payload),
      .state           (slot_state[k]),
      .dest            (slot_dest[k]),
      .payload         (slot_payload[k])
    );
  end

  // Lowest free slot takes the incoming micro-op
  always_comb begin
    load = '0;
    for (int k = IQ_SIZE - 1; k >= 0; k--) begin
      if (free[k]) begin
        load    = '0;
        load[k] = disp.valid;
      end
    end
  end

  always_comb begin
    free_count = '0;
    for (int k = 0; k < IQ_SIZE; k++) begin
      if (free[k]) begin
        free_count = free_count + 1'b1;
      end
    end
  end

  // Margin of two leaves room for the micro-op in the dispatch register
  assign almost_full = (free_count < 2);

  // Ready slots fill the issue lanes lowest index first
  always_comb begin
    int unsigned lane;
    lane        = 0;
    grant       = '0;
    iss.valid   = '0;
    iss.dest    = '0;
    iss.payload = '0;
    for (int k = 0; k < IQ_SIZE; k++) begin
      if (ready[k] && lane < ISSUE_WIDTH) begin
        grant[k]          = 1'b1;
        iss.valid[lane]   = 1'b1;
        iss.dest[lane]    = slot_dest[k];
        iss.payload[lane] = slot_payload[k];
        lane              = lane + 1;
      end
    end
  end

  assert property (@(posedge clock) disable iff (reset) disp.valid |-> |free)
    else $error("dispatched micro-op found no free slot");

  // Two busy lanes never carry the same micro-op
  for (genvar a = 0; a < ISSUE_WIDTH; a++) begin : g_lane_a
    for (genvar b = a + 1; b < ISSUE_WIDTH; b++) begin : g_lane_b
      assert property (@(posedge clock) disable iff (reset)
        (iss.valid[a] && iss.valid[b]) |-> iss.dest[a] != iss.dest[b])
        else $error("micro-op granted to more than one lane");
    end
  end

endmodule

`default_nettype wire

// ==== source/exec_pipes.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_pipes
  import issue_pkg::*;
#(
  parameter int ISSUE_WIDTH  = 2,
  parameter int EXEC_LATENCY = 2
) (
  input  logic                       clock,
  input  logic                       reset,
  issue_if.sink                      iss,
  output logic     [ISSUE_WIDTH-1:0] ctb_valid,
  output tag_t     [ISSUE_WIDTH-1:0] ctb_tag,
  output logic     [ISSUE_WIDTH-1:0] done_valid,
  output tag_t     [ISSUE_WIDTH-1:0] done_tag,
  output payload_t [ISSUE_WIDTH-1:0] done_payload
);

  for (genvar l = 0; l < ISSUE_WIDTH; l++) begin : g_lane
    logic [EXEC_LATENCY-1:0] stage_valid;
    tag_t                    stage_tag     [EXEC_LATENCY];
    payload_t                stage_payload [EXEC_LATENCY];

    always_ff @(posedge clock) begin
      if (reset) begin
        stage_valid <= '0;
      end else begin
        stage_valid[0] <= iss.valid[l];
        for (int s = 1; s < EXEC_LATENCY; s++) begin
          stage_valid[s] <= stage_valid[s-1];
        end
      end
    end

    always_ff @(posedge clock) begin
      stage_tag[0]     <= iss.dest[l];
      stage_payload[0] <= iss.payload[l];
      for (int s = 1; s < EXEC_LATENCY; s++) begin
        stage_tag[s]     <= stage_tag[s-1];
        stage_payload[s] <= stage_payload[s-1];
      end
    end

    // Last stage completes and wakes dependents in the same cycle
    assign ctb_valid[l]    = stage_valid[EXEC_LATENCY-1];
    assign ctb_tag[l]      = stage_tag[EXEC_LATENCY-1];
    assign done_payload[l] = stage_payload[EXEC_LATENCY-1];
  end

  assign done_valid = ctb_valid;
  assign done_tag   = ctb_tag;

endmodule

`default_nettype wire

// ==== source/issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_top
  import issue_pkg::*;
#(
  parameter int IQ_SIZE      = 8,
  parameter int ISSUE_WIDTH  = 2,
  parameter int EXEC_LATENCY = 2
) (
  input  logic                       clock,
  input  logic                       reset,
  input  logic                       in_valid,
  input  tag_t                       in_dest,
  input  tag_t                       in_src1,
  input  tag_t                       in_src2,
  input  logic                       in_src1_used,
  input  logic                       in_src2_used,
  input  payload_t                   in_payload,
  output logic                       in_ready,
  output logic     [ISSUE_WIDTH-1:0] done_valid,
  output tag_t     [ISSUE_WIDTH-1:0] done_tag,
  output payload_t [ISSUE_WIDTH-1:0] done_payload
);

  logic                   almost_full;
  logic [ISSUE_WIDTH-1:0] ctb_valid;
  tag_t [ISSUE_WIDTH-1:0] ctb_tag;

  dispatch_if disp_bus ();
  issue_if #(.ISSUE_WIDTH(ISSUE_WIDTH)) iss_bus ();

  dispatch_stage #(
    .ISSUE_WIDTH (ISSUE_WIDTH)
  ) u_dispatch (
    .clock        (clock),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_dest      (in_dest),
    .in_src1      (in_src1),
    .in_src2      (in_src2),
    .in_src1_used (in_src1_used),
    .in_src2_used (in_src2_used),
    .in_payload   (in_payload),
    .in_ready     (in_ready),
    .almost_full  (almost_full),
    .ctb_valid    (ctb_valid),
    .ctb_tag      (ctb_tag),
    .disp         (disp_bus.source)
  );

  issue_queue #(
    .IQ_SIZE     (IQ_SIZE),
    .ISSUE_WIDTH (ISSUE_WIDTH)
  ) u_queue (
    .clock       (clock),
    .reset       (reset),
    .disp        (disp_bus.sink),
    .ctb_valid   (ctb_valid),
    .ctb_tag     (ctb_tag),
    .almost_full (almost_full),
    .iss         (iss_bus.source)
  );

  exec_pipes #(
    .ISSUE_WIDTH  (ISSUE_WIDTH),
    .EXEC_LATENCY (EXEC_LATENCY)
  ) u_exec (
    .clock        (clock),
    .reset        (reset),
    .iss          (iss_bus.sink),
    .ctb_valid    (ctb_valid),
    .ctb_tag      (ctb_tag),
    .done_valid   (done_valid),
    .done_tag     (done_tag),
    .done_payload (done_payload)
  );

endmodule

`default_nettype wire

// ==== sim/issue_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_tb
  import issue_pkg::*;
();

  localparam int IQ_SIZE       = 8;
  localparam int ISSUE_WIDTH   = 2;
  localparam int EXEC_LATENCY  = 2;
  localparam int RESET_CYCLES  = 8;
  localparam int CHAIN_LEN     = 12;
  localparam int BURST_DEPS    = 12;
  localparam int RANDOM_CYCLES = 400;
  // Queue, dispatch register and execute stages
  localparam int CAPACITY      = IQ_SIZE + 1 + ISSUE_WIDTH * EXEC_LATENCY;
  localparam int LINK_CYCLES   = EXEC_LATENCY + 2;
  localparam int PHASE_CYCLES  = 20 + (CHAIN_LEN * LINK_CYCLES + 20)
                               + (3 * LINK_CYCLES + 2 * BURST_DEPS + 20) + RANDOM_CYCLES;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + PHASE_CYCLES + 200;

  logic                       clock;
  logic                       reset;
  logic                       in_valid;
  tag_t                       in_dest;
  tag_t                       in_src1;
  tag_t                       in_src2;
  logic                       in_src1_used;
  logic                       in_src2_used;
  payload_t                   in_payload;
  logic                       in_ready;
  logic     [ISSUE_WIDTH-1:0] done_valid;
  tag_t     [ISSUE_WIDTH-1:0] done_tag;
  payload_t [ISSUE_WIDTH-1:0] done_payload;

  // Reference model, indexed by tag or by dispatch sequence number
  logic [15:0] lfsr;
  tag_t        free_tags [$];
  logic        live       [2**TAG_W];
  payload_t    payload_of [2**TAG_W];
  int          seq_of_tag [2**TAG_W];
  int          wait_seq1  [2**TAG_W];
  int          wait_seq2  [2**TAG_W];
  int          done_at    [1024];
  int          cycle;
  int          outstanding;
  int          accepted_count;
  int          completed_count;
  int          error_count;
  logic        probe;
  logic        saw_backpressure;
  logic        saw_full_width;

  issue_top dut (
    .clock        (clock),
    .reset        (reset),
    .in_valid     (in_valid),
    .in_dest      (in_dest),
    .in_src1      (in_src1),
    .in_src2      (in_src2),
    .in_src1_used (in_src1_used),
    .in_src2_used (in_src2_used),
    .in_payload   (in_payload),
    .in_ready     (in_ready),
    .done_valid   (done_valid),
    .done_tag     (done_tag),
    .done_payload (done_payload)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle <= cycle + 1;
  end

  task automatic report_error(input string msg);
    error_count++;
    $display("** Error @ %0t ns: %s", $time, msg);
  endtask

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = (v << 1) | lfsr[0];
    end
    return v;
  endfunction

  task automatic idle_cycle();
    in_valid = 1'b0;
    @(posedge clock);
    #1;
  endtask

  // Holds the micro-op until the DUT takes it
  task automatic send_uop(input tag_t s1, input logic u1, input tag_t s2, input logic u2,
                          output tag_t dest);
    logic accepted;
    while (free_tags.size() == 0) begin
      idle_cycle();
    end
    dest         = free_tags.pop_front();
    in_valid     = 1'b1;
    in_dest      = dest;
    in_src1      = s1;
    in_src1_used = u1;
    in_src2      = s2;
    in_src2_used = u2;
    in_payload   = payload_t'(take_bits(PAYLOAD_W));
    accepted     = 1'b0;
    while (!accepted) begin
      @(negedge clock);
      accepted = in_ready;
      @(posedge clock);
      #1;
    end
    in_valid = 1'b0;
  endtask

  task automatic drain_queue();
    in_valid = 1'b0;
    while (outstanding != 0) begin
      @(posedge clock);
      #1;
    end
    repeat (2) idle_cycle();
  endtask

  // Monitor at the falling edge, where inputs and outputs are settled
  always @(negedge clock) begin
    tag_t t;
    int   w1;
    int   w2;
    if (!reset) begin
      for (int l = 0; l < ISSUE_WIDTH; l++) begin
        if (done_valid[l]) begin
          t = done_tag[l];
          assert (live[t])
            else report_error($sformatf("tag %0d completed but is not in flight", t));
          if (live[t]) begin
            assert (done_payload[l] == payload_of[t])
              else report_error($sformatf("tag %0d payload %0h, expected %0h",
                                          t, done_payload[l], payload_of[t]));
            w1 = wait_seq1[t];
            w2 = wait_seq2[t];
            assert (w1 < 0 || (done_at[w1] >= 0 && cycle - done_at[w1] >= EXEC_LATENCY))
              else report_error($sformatf("tag %0d completed before its first source", t));
            assert (w2 < 0 || (done_at[w2] >= 0 && cycle - done_at[w2] >= EXEC_LATENCY))
              else report_error($sformatf("tag %0d completed before its second source", t));
            live[t]                = 1'b0;
            done_at[seq_of_tag[t]] = cycle;
            outstanding--;
            completed_count++;
            free_tags.push_back(t);
          end
        end
      end
      if (in_valid && !in_ready) begin
        saw_backpressure = 1'b1;
      end
      if (&done_valid) begin
        saw_full_width = 1'b1;
      end
      if (in_valid && in_ready) begin
        // Busy table rule with tags on the bus already cleared above
        wait_seq1[in_dest]  = (in_src1_used && live[in_src1]) ? seq_of_tag[in_src1] : -1;
        wait_seq2[in_dest]  = (in_src2_used && live[in_src2]) ? seq_of_tag[in_src2] : -1;
        live[in_dest]       = 1'b1;
        payload_of[in_dest] = in_payload;
        seq_of_tag[in_dest] = accepted_count;
        accepted_count++;
        outstanding++;
      end
      assert (outstanding <= CAPACITY)
        else report_error($sformatf("%0d micro-ops in flight, limit %0d", outstanding, CAPACITY));
    end
  end

  assert property (@(posedge clock) $fell(reset) |-> in_ready && done_valid == '0)
    else report_error("in_ready low or done_valid set after reset");

  // Single independent micro-op into an empty queue
  assert property (@(posedge clock) disable iff (reset)
    (in_valid && in_ready && probe) |-> ##(2 + EXEC_LATENCY)
      (done_valid[0] && done_tag[0] == $past(in_dest, 2 + EXEC_LATENCY)))
    else report_error("directed micro-op missed its completion edge");

  // Lanes fill from lane 0 upward
  assert property (@(posedge clock) disable iff (reset)
    ((done_valid + 1) & done_valid) == 0)
    else report_error($sformatf("done lanes out of order: %b", done_valid));

  assert property (@(posedge clock) disable iff (reset) !$isunknown(done_valid))
    else report_error("done_valid is unknown");

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    tag_t d;
    tag_t prev;
    tag_t s1;
    tag_t s2;
    logic u1;
    logic u2;
    int   start;
    reset = 1'b1;
    in_valid = 1'b0;
    in_dest = '0;
    in_src1 = '0;
    in_src2 = '0;
    in_src1_used = 1'b0;
    in_src2_used = 1'b0;
    in_payload = '0;
    lfsr = 16'd59517;
    cycle = 0;
    outstanding = 0;
    accepted_count = 0;
    completed_count = 0;
    error_count = 0;
    probe = 1'b0;
    saw_backpressure = 1'b0;
    saw_full_width = 1'b0;
    for (int i = 0; i < 2**TAG_W; i++) begin
      free_tags.push_back(tag_t'(i));
      live[i] = 1'b0;
    end
    for (int i = 0; i < 1024; i++) begin
      done_at[i] = -1;
    end
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    idle_cycle();

    probe = 1'b1;
    send_uop('0, 1'b0, '0, 1'b0, d);
    probe = 1'b0;
    drain_queue();

    // Each link waits on the one before it
    send_uop('0, 1'b0, '0, 1'b0, prev);
    for (int i = 1; i < CHAIN_LEN; i++) begin
      send_uop(prev, 1'b1, '0, 1'b0, d);
      prev = d;
    end
    drain_queue();
    assert (saw_backpressure) else report_error("in_ready never dropped during the chain");

    // Short chain, then a burst that wakes on its last link
    send_uop('0, 1'b0, '0, 1'b0, prev);
    send_uop(prev, 1'b1, '0, 1'b0, prev);
    send_uop(prev, 1'b1, '0, 1'b0, prev);
    for (int i = 0; i < BURST_DEPS; i++) begin
      send_uop('0, 1'b0, prev, 1'b1, d);
    end
    drain_queue();
    assert (saw_full_width) else report_error("all execute lanes never completed together");

    start = cycle;
    prev  = '0;
    while (cycle - start < RANDOM_CYCLES) begin
      if (take_bits(2) != 0) begin
        if (take_bits(1) != 0) begin
          s1 = prev;
        end else begin
          s1 = tag_t'(take_bits(TAG_W));
        end
        u1 = 1'(take_bits(1));
        s2 = tag_t'(take_bits(TAG_W));
        u2 = 1'(take_bits(1));
        send_uop(s1, u1, s2, u2, prev);
      end else begin
        idle_cycle();
      end
    end
    drain_queue();
    assert (accepted_count == completed_count)
      else report_error($sformatf("%0d accepted but %0d completed",
                                  accepted_count, completed_count));

    $display("Run complete: %0d dispatched, %0d completed, %0d errors",
             accepted_count, completed_count, error_count);
    if (error_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
source/issue_pkg.sv
source/dispatch_if.sv
source/issue_if.sv
source/dispatch_stage.sv
source/issue_slot.sv
source/issue_queue.sv
source/exec_pipes.sv
source/issue_top.sv
sim/issue_tb.sv
